// File: cpu_core.sv
`timescale 1ns/100ps

module cpu_core
    import cpu_isa_pkg::*, cpu_pipe_pkg::*;
(
    input  logic  Clock,
    input  logic  Reset,
    input  word_t instr_in,
    output word_t instr_addr,
    input  word_t data_in,
    input  logic  data_done,
    output word_t data_out,
    output word_t data_addr,
    output logic  read_data,
    output logic  write_data
);

    reg_addr_t rd_addr_a;
    reg_addr_t rd_addr_b;
    word_t     rd_data_a;
    word_t     rd_data_b;
    logic      wb_en;
    reg_addr_t wb_reg;
    word_t     wb_data;
    logic      pc_write;
    word_t     pc_next;
    word_t     pc_value;
    decoded_t  decode_out;
    decoded_t  exec_out;
    reg_addr_t exec_dest;
    logic      exec_wb;
    reg_addr_t mem_dest;
    logic      mem_wb;
    reg_addr_t wb_dest;
    logic      wb_wb;
    logic      mem_wait;   // freezes fetch, decode and execute

    cpu_register_file u_register_file (
        .Clock     (Clock),
        .Reset     (Reset),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wb_en     (wb_en),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data),
        .pc_write  (pc_write),
        .pc_next   (pc_next),
        .pc_value  (pc_value)
    );

    cpu_fetch_decode u_fetch_decode (
        .Clock      (Clock),
        .Reset      (Reset),
        .instr_in   (instr_in),
        .instr_addr (instr_addr),
        .pc_value   (pc_value),
        .pc_write   (pc_write),
        .pc_next    (pc_next),
        .rd_addr_a  (rd_addr_a),
        .rd_addr_b  (rd_addr_b),
        .rd_data_a  (rd_data_a),
        .rd_data_b  (rd_data_b),
        .mem_wait   (mem_wait),
        .exec_dest  (exec_dest),
        .exec_wb    (exec_wb),
        .mem_dest   (mem_dest),
        .mem_wb     (mem_wb),
        .wb_dest    (wb_dest),
        .wb_wb      (wb_wb),
        .decode_out (decode_out)
    );

    cpu_execute u_execute (
        .Clock      (Clock),
        .Reset      (Reset),
        .decode_out (decode_out),
        .mem_wait   (mem_wait),
        .exec_out   (exec_out),
        .exec_dest  (exec_dest),
        .exec_wb    (exec_wb)
    );

    cpu_result u_result (
        .Clock      (Clock),
        .Reset      (Reset),
        .exec_out   (exec_out),
        .data_in    (data_in),
        .data_done  (data_done),
        .data_addr  (data_addr),
        .data_out   (data_out),
        .read_data  (read_data),
        .write_data (write_data),
        .mem_wait   (mem_wait),
        .mem_dest   (mem_dest),
        .mem_wb     (mem_wb),
        .wb_en      (wb_en),
        .wb_reg     (wb_reg),
        .wb_data    (wb_data),
        .wb_dest    (wb_dest),
        .wb_wb      (wb_wb)
    );

endmodule

// File: cpu_execute.sv
`timescale 1ns/100ps

module cpu_execute
    import cpu_isa_pkg::*, cpu_pipe_pkg::*;
(
    input  logic      Clock,
    input  logic      Reset,
    input  decoded_t  decode_out,
    input  logic      mem_wait,
    output decoded_t  exec_out,
    output reg_addr_t exec_dest,
    output logic      exec_wb
);

    localparam int msb = word_width - 1;

    status_t  status_q;
    status_t  status_next;
    decoded_t exec_next;
    word_t    alu_result;
    logic     alu_carry;
    logic     cond_met;

    always_comb begin
        alu_carry  = 1'b0;
        alu_result = '0;
        case (decode_out.alu_op)
            alu_mov: alu_result = decode_out.op2;
            alu_add: {alu_carry, alu_result} = {1'b0, decode_out.op1} + {1'b0, decode_out.op2};
            alu_sub: {alu_carry, alu_result} = {1'b0, decode_out.op1} - {1'b0, decode_out.op2};
            default: alu_result = '0;  // ld and st need no alu
        endcase
    end

    always_comb begin
        case (decode_out.cond)
            cond_eq: cond_met = status_q.zero;
            cond_ne: cond_met = !status_q.zero;
            cond_cc: cond_met = !status_q.carry;
            cond_cs: cond_met = status_q.carry;
            cond_pl: cond_met = !status_q.zero && !status_q.negative;
            cond_mi: cond_met = !status_q.zero && status_q.negative;
            default: cond_met = 1'b1;
        endcase
    end

    always_comb begin
        exec_next        = decode_out;
        exec_next.result = alu_result;
        status_next      = status_q;
        if (!cond_met) begin
            exec_next = decoded_nop;  // failed branch drops out here
        end else if (decode_out.update_flags) begin
            status_next.negative = alu_result[msb];
            status_next.zero     = (alu_result == '0);
            status_next.carry    = alu_carry;
            // overflow only tracked on subtract
            status_next.overflow = (decode_out.alu_op == alu_sub)
                                && (decode_out.op1[msb] != decode_out.op2[msb])
                                && (decode_out.op1[msb] != alu_result[msb]);
        end
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            exec_out <= decoded_nop;
            status_q <= '0;
        end else if (!mem_wait) begin  // hold while the data bus is busy
            exec_out <= exec_next;
            status_q <= status_next;
        end
    end

    assign exec_dest = exec_out.dest;
    assign exec_wb   = exec_out.writeback;

endmodule

// File: cpu_fetch_decode.sv
`timescale 1ns/100ps

module cpu_fetch_decode
    import cpu_isa_pkg::*, cpu_pipe_pkg::*;
(
    input  logic      Clock,
    input  logic      Reset,
    input  word_t     instr_in,
    output word_t     instr_addr,
    input  word_t     pc_value,
    output logic      pc_write,
    output word_t     pc_next,
    output reg_addr_t rd_addr_a,
    output reg_addr_t rd_addr_b,
    input  word_t     rd_data_a,
    input  word_t     rd_data_b,
    input  logic      mem_wait,
    input  reg_addr_t exec_dest,
    input  logic      exec_wb,
    input  reg_addr_t mem_dest,
    input  logic      mem_wb,
    input  reg_addr_t wb_dest,
    input  logic      wb_wb,
    output decoded_t  decode_out
);

    word_t     fetch_q;     // instruction word, all zero means nop
    decoded_t  dec;
    opcode_t   opcode;
    reg_addr_t rx;
    reg_addr_t ry;
    logic      imm_bit;
    word_t     imm_ext;
    logic      is_branch_word;
    logic      uses_y;
    logic      hit_x;
    logic      hit_y;
    logic      pc_busy;     // something later in the pipe still writes r7
    logic      raw_hazard;
    logic      stall;
    logic      redirect;
    logic      advance;

    function automatic logic dest_hit(reg_addr_t r, reg_addr_t d, logic wb);
        return wb && (d == r);
    endfunction

    assign opcode  = opcode_t'(fetch_q[word_width-1 -: opcode_bits]);
    assign imm_bit = fetch_q[imm_pos];
    assign rx      = fetch_q[rx_lsb +: reg_bits];
    assign ry      = fetch_q[reg_bits-1:0];
    assign imm_ext = {{(word_width-imm_width){fetch_q[imm_width-1]}}, fetch_q[imm_width-1:0]};

    // a branch adds its offset to r7, so port A reads the pc instead of rX
    assign is_branch_word = (opcode == op_mvt_b) && !imm_bit;
    assign rd_addr_a      = is_branch_word ? pc_reg : rx;
    assign rd_addr_b      = ry;

    always_comb begin
        dec = decoded_nop;
        if (fetch_q != '0) begin
            dec.dest      = rx;
            dec.imm       = imm_bit;
            dec.writeback = 1'b1;
            dec.op1       = rd_data_a;
            dec.op2       = imm_bit ? imm_ext : rd_data_b;
            case (opcode)
                op_mv: begin
                    dec.instr  = i_mov;
                    dec.alu_op = alu_mov;
                end
                op_mvt_b: begin
                    if (imm_bit) begin
                        dec.instr  = i_mvt;
                        dec.alu_op = alu_mov;
                        dec.op2    = imm_ext << mvt_shift;
                    end else if (rx != 3'd7) begin  // code 7 is link, not supported
                        dec.instr  = i_branch;
                        dec.alu_op = alu_add;
                        dec.cond   = cond_t'(rx);
                        dec.imm    = 1'b1;
                        dec.op2    = imm_ext;
                        dec.dest   = pc_reg;
                    end else begin
                        dec = decoded_nop;
                    end
                end
                op_add: begin
                    dec.instr  = i_add;
                    dec.alu_op = alu_add;
                end
                op_sub: begin
                    dec.instr  = i_sub;
                    dec.alu_op = alu_sub;
                end
                op_ld: begin
                    dec.instr = i_load;
                    dec.read  = 1'b1;
                end
                op_st: begin
                    dec.instr     = i_store;
                    dec.write     = 1'b1;
                    dec.writeback = 1'b0;
                end
                op_other: begin
                    // register form of cmp needs the spare bits clear
                    if (imm_bit || fetch_q[imm_width-1:reg_bits] == '0) begin
                        dec.instr        = i_cmp;
                        dec.alu_op       = alu_sub;
                        dec.update_flags = 1'b1;
                        dec.writeback    = 1'b0;
                    end else begin
                        dec = decoded_nop;
                    end
                end
                default: dec = decoded_nop;
            endcase
        end
    end

    // read-after-write check against decode, execute and memory
    assign hit_x = dest_hit(rd_addr_a, decode_out.dest, decode_out.writeback)
                 | dest_hit(rd_addr_a, exec_dest, exec_wb)
                 | dest_hit(rd_addr_a, mem_dest, mem_wb);
    assign hit_y = dest_hit(ry, decode_out.dest, decode_out.writeback)
                 | dest_hit(ry, exec_dest, exec_wb)
                 | dest_hit(ry, mem_dest, mem_wb);
    assign uses_y     = (dec.instr != i_nop) && !dec.imm;
    assign raw_hazard = (dec.instr != i_nop) && (hit_x || (uses_y && hit_y));

    assign pc_busy = dest_hit(pc_reg, decode_out.dest, decode_out.writeback)
                   | dest_hit(pc_reg, exec_dest, exec_wb)
                   | dest_hit(pc_reg, mem_dest, mem_wb)
                   | dest_hit(pc_reg, wb_dest, wb_wb);

    assign stall    = raw_hazard || pc_busy;
    assign redirect = dec.writeback && (dec.dest == pc_reg);  // branch or other r7 write
    assign advance  = !mem_wait && !stall && !redirect;

    assign pc_write   = advance;
    assign pc_next    = pc_value + word_t'(1);
    assign instr_addr = advance ? pc_next : pc_value;

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            fetch_q    <= '0;
            decode_out <= decoded_nop;
        end else if (!mem_wait) begin
            decode_out <= stall ? decoded_nop : dec;
            if (advance) begin
                fetch_q <= instr_in;
            end else if (!stall) begin
                fetch_q <= '0;  // redirect taken by decode, wait for the new r7
            end
        end
    end

    a_no_ld_st: assert property (@(posedge Clock) disable iff (Reset)
        !(decode_out.read && decode_out.write))
        else $error("decode issued a load and a store at once");

endmodule

// File: cpu_isa_pkg.sv
package cpu_isa_pkg;

    localparam int word_width  = 16;
    localparam int reg_count   = 8;
    localparam int reg_bits    = 3;
    localparam int opcode_bits = 3;

    // instruction word fields
    localparam int imm_pos    = 12;  // immediate select bit
    localparam int rx_lsb     = 9;   // rX sits in bits 11:9
    localparam int imm_width  = 9;   // signed immediate in bits 8:0
    localparam int mvt_shift  = 8;   // mvt loads the upper byte

    typedef logic [word_width-1:0] word_t;
    typedef logic [reg_bits-1:0]   reg_addr_t;

    localparam reg_addr_t pc_reg = 3'd7;  // r7 doubles as program counter

    // major opcodes, top three bits of the instruction
    typedef enum logic [opcode_bits-1:0] {
        op_mv    = 3'b000,
        op_mvt_b = 3'b001,  // mvt when imm is set, branch otherwise
        op_add   = 3'b010,
        op_sub   = 3'b011,
        op_ld    = 3'b100,
        op_st    = 3'b101,
        op_and   = 3'b110,
        op_other = 3'b111   // only cmp is decoded here
    } opcode_t;

    typedef enum logic [3:0] {
        i_nop, i_mov, i_mvt, i_branch, i_add, i_sub, i_load, i_store, i_cmp
    } instr_t;

    typedef enum logic [1:0] {
        no_alu, alu_mov, alu_add, alu_sub
    } alu_op_t;

    // branch condition, taken from the rX field of a branch
    typedef enum logic [2:0] {
        cond_none = 3'd0,
        cond_eq   = 3'd1,
        cond_ne   = 3'd2,
        cond_cc   = 3'd3,
        cond_cs   = 3'd4,
        cond_pl   = 3'd5,
        cond_mi   = 3'd6
    } cond_t;

    typedef struct packed {
        logic negative;
        logic zero;
        logic carry;
        logic overflow;
    } status_t;

endpackage

// File: cpu_pipe_pkg.sv
package cpu_pipe_pkg;

    import cpu_isa_pkg::*;

    // record handed from stage to stage
    typedef struct packed {
        word_t     op1;           // rX value, or store data
        word_t     op2;           // rY value or immediate, or memory address
        word_t     result;        // alu output, later the load data
        reg_addr_t dest;
        logic      imm;
        logic      writeback;     // result goes to dest
        logic      read;
        logic      write;
        instr_t    instr;
        alu_op_t   alu_op;
        logic      update_flags;
        cond_t     cond;
    } decoded_t;

    // bubble inserted on stalls and failed conditions
    localparam decoded_t decoded_nop = '{
        op1:          '0,
        op2:          '0,
        result:       '0,
        dest:         '0,
        imm:          1'b0,
        writeback:    1'b0,
        read:         1'b0,
        write:        1'b0,
        instr:        i_nop,
        alu_op:       no_alu,
        update_flags: 1'b0,
        cond:         cond_none
    };

endpackage

// File: cpu_register_file.sv
`timescale 1ns/100ps

module cpu_register_file
    import cpu_isa_pkg::*;
(
    input  logic      Clock,
    input  logic      Reset,
    input  reg_addr_t rd_addr_a,
    input  reg_addr_t rd_addr_b,
    output word_t     rd_data_a,
    output word_t     rd_data_b,
    input  logic      wb_en,
    input  reg_addr_t wb_reg,
    input  word_t     wb_data,
    input  logic      pc_write,
    input  word_t     pc_next,
    output word_t     pc_value
);

    word_t regs [reg_count];

    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];
    assign pc_value  = regs[pc_reg];

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
            regs[pc_reg] <= '1;  // first fetch increments to address 0
        end else begin
            if (pc_write) begin
                regs[pc_reg] <= pc_next;
            end
            // a writeback to r7 comes last and overrides the fetch increment
            if (wb_en) begin
                regs[wb_reg] <= wb_data;
            end
        end
    end

    // decode always presents a known read address once the fetch register is loaded
    a_rd_addr_known: assert property (@(posedge Clock) disable iff (Reset)
        !$isunknown(rd_addr_a))
        else $error("register read address A is unknown");

endmodule

// File: cpu_result.sv
`timescale 1ns/100ps

module cpu_result
    import cpu_isa_pkg::*, cpu_pipe_pkg::*;
(
    input  logic      Clock,
    input  logic      Reset,
    input  decoded_t  exec_out,
    input  word_t     data_in,
    input  logic      data_done,
    output word_t     data_addr,
    output word_t     data_out,
    output logic      read_data,
    output logic      write_data,
    output logic      mem_wait,
    output reg_addr_t mem_dest,
    output logic      mem_wb,
    output logic      wb_en,
    output reg_addr_t wb_reg,
    output word_t     wb_data,
    output reg_addr_t wb_dest,
    output logic      wb_wb
);

    decoded_t  mem_q;      // memory stage register, written back next cycle
    decoded_t  mem_next;
    reg_addr_t wb_dest_q;
    logic      wb_wb_q;
    logic      mem_access;

    assign mem_access = exec_out.read || exec_out.write;
    assign read_data  = exec_out.read;
    assign write_data = exec_out.write;
    assign data_addr  = mem_access ? exec_out.op2 : '0;
    assign data_out   = exec_out.write ? exec_out.op1 : '0;
    assign mem_wait   = mem_access && !data_done;  // request held until done

    always_comb begin
        mem_next = exec_out;
        if (exec_out.read) begin
            mem_next.result = data_in;
        end
        if (mem_wait) begin
            mem_next = decoded_nop;
        end
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            mem_q     <= decoded_nop;
            wb_dest_q <= '0;
            wb_wb_q   <= 1'b0;
        end else begin
            mem_q     <= mem_next;
            wb_dest_q <= mem_q.dest;
            wb_wb_q   <= mem_q.writeback;
        end
    end

    assign wb_en    = mem_q.writeback;
    assign wb_reg   = mem_q.dest;
    assign wb_data  = mem_q.result;
    assign mem_dest = mem_q.dest;
    assign mem_wb   = mem_q.writeback;
    assign wb_dest  = wb_dest_q;
    assign wb_wb    = wb_wb_q;

    a_rd_wr_excl: assert property (@(posedge Clock) disable iff (Reset)
        !(read_data && write_data))
        else $error("data bus read and write asserted together");

    // execute must keep the request steady while the bus waits
    a_req_stable: assert property (@(posedge Clock) disable iff (Reset)
        mem_wait |=> (read_data || write_data) && $stable(data_addr) && $stable(data_out))
        else $error("data bus request changed before done");

endmodule

// File: cpu_stim.txt
// instruction ROM at 00, preset data words at 40, expected stores at 80
// (address then value), run info at F0: program length, halt address,
// store count, preset data count
@00
1C10 1005 13FF 4001 A006 5C01 3412 5434  // mv, add reg with RAW, mvt, add imm
A406 5C01 7434 0602 6600 A606 5C01 1800  // sub imm, mv reg, sub reg
8A04 9001 4A00 AA06 5C01 E000 2001 5C01  // ld reg and imm, cmp r0,r0, b none
AC06 2201 5C01 AC06 2401 5C01 AC06 2601  // beq taken, bne not, bcc taken
5C01 AC06 2A01 5C01 AC06 E005 2801 5C01  // bpl not, cmp r0,r5, bcs taken
AC06 2C01 5C01 AC06 EA00 2C01 5C01 AC06  // bmi not, cmp r5,r0, bmi taken
21FF                                     // halt, branch to self
@40
A5A0 0123
@80
0010 0004 0011 1234 0012 11FC 0013 A6C3
0014 0014 0014 0014 0015 0015 0015 0015
0016 0016 0016 0016 0017 0017 0017 0017
@F0
0031 0030 000C 0002

// File: project.f
cpu_isa_pkg.sv
cpu_pipe_pkg.sv
cpu_register_file.sv
cpu_fetch_decode.sv
cpu_execute.sv
cpu_result.sv
cpu_core.sv
tb_cpu_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench, verdict taken from the log
verilator --binary --timing --assert --top-module tb_cpu_core -f project.f -o sim_tb \
    || exit 1
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "Done: errors found" sim.log && echo "simulation FAILED" && exit 1
grep -q "Done: no errors" sim.log || { echo "simulation gave no verdict"; exit 1; }
echo "simulation PASSED"

// File: tb_cpu_core.sv
`timescale 1ns/100ps

module tb_cpu_core
    import cpu_isa_pkg::*;
();

    localparam int stim_depth = 256;
    localparam int data_base  = 'h40;  // preset data words
    localparam int store_base = 'h80;  // expected stores, address then value
    localparam int info_base  = 'hF0;  // program length, halt address, counts
    localparam int dmem_depth = 32;
    localparam int halt_hits  = 16;    // halt fetches seen before the run ends

    logic   Clock      = 1'b0;
    logic   Reset      = 1'b1;
    word_t  data_in    = '0;
    logic   data_done  = 1'b0;
    word_t  instr_in;
    word_t  instr_addr;
    word_t  data_out;
    word_t  data_addr;
    logic   read_data;
    logic   write_data;

    word_t  stim [stim_depth];
    word_t  dmem [dmem_depth];
    word_t  prog_len    = '0;
    word_t  halt_addr   = '1;
    int     store_count = 0;
    int     data_count  = 0;
    logic   loaded      = 1'b0;

    integer seed      = 63609;
    int     store_idx = 0;
    int     halt_seen = 0;
    int     wait_left = 0;
    logic   busy      = 1'b0;  // a bus request is being served
    word_t  req_addr  = '0;
    word_t  req_data  = '0;
    logic   req_write = 1'b0;

    cpu_core u_cpu_core (
        .Clock      (Clock),
        .Reset      (Reset),
        .instr_in   (instr_in),
        .instr_addr (instr_addr),
        .data_in    (data_in),
        .data_done  (data_done),
        .data_out   (data_out),
        .data_addr  (data_addr),
        .read_data  (read_data),
        .write_data (write_data)
    );

    always #4 Clock = ~Clock;

    // instruction ROM, nop past the end of the program
    assign instr_in = (instr_addr < prog_len) ? stim[instr_addr[7:0]] : '0;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_store(input word_t addr, input word_t value);
        string name;
        name = $sformatf("store %0d", store_idx);
        assert (store_idx < store_count)
            else fail_now($sformatf("unexpected extra store to address %h", addr));
        assert (addr == stim[store_base + 2 * store_idx])
            else fail_now($sformatf("mismatch %s address: expected %h actual %h",
                                    name, stim[store_base + 2 * store_idx], addr));
        assert (value == stim[store_base + 2 * store_idx + 1])
            else fail_now($sformatf("mismatch %s value: expected %h actual %h",
                                    name, stim[store_base + 2 * store_idx + 1], value));
        store_idx++;
    endtask

    initial begin
        $readmemh("cpu_stim.txt", stim);
        prog_len    = stim[info_base];
        halt_addr   = stim[info_base + 1];
        store_count = int'(stim[info_base + 2]);
        data_count  = int'(stim[info_base + 3]);
        for (int i = 0; i < dmem_depth; i++) begin
            dmem[i] = word_t'(16'h5A00 ^ (i * 16'h0101));  // background fill
        end
        for (int i = 0; i < data_count; i++) begin
            dmem[i] = stim[data_base + i];
        end
        loaded = 1'b1;
        repeat (16) @(posedge Clock);
        @(negedge Clock);
        Reset = 1'b0;
        assert (instr_addr == '0)
            else fail_now($sformatf("mismatch reset fetch address: expected %h actual %h",
                                    16'h0000, instr_addr));
        assert (!read_data && !write_data)
            else fail_now("data bus request active right after reset");
        wait (halt_seen >= halt_hits);
        if (store_idx == store_count) begin
            $display("Done: no errors");
            $finish;
        end else begin
            fail_now($sformatf("program halted after %0d of %0d expected stores",
                               store_idx, store_count));
        end
    end

    // data memory model with a random done delay, plus halt detection
    always @(negedge Clock) begin
        if (!Reset) begin
            if (instr_addr == halt_addr) begin
                halt_seen++;
            end
            if (data_done) begin  // transfer completed on the last rising edge
                data_done = 1'b0;
                busy      = 1'b0;
            end
            if ((read_data || write_data) && !busy) begin
                busy      = 1'b1;
                req_addr  = data_addr;
                req_data  = data_out;
                req_write = write_data;
                wait_left = $random(seed) & 3;
            end
            if (busy) begin
                assert ((read_data || write_data) && data_addr == req_addr
                        && data_out == req_data && write_data == req_write)
                    else fail_now("data bus request changed while waiting for done");
                assert (req_addr < word_t'(dmem_depth))
                    else fail_now($sformatf("data address %h outside the memory", req_addr));
                if (wait_left == 0) begin
                    if (req_write) begin
                        check_store(req_addr, req_data);
                    end else begin
                        data_in = dmem[req_addr[4:0]];
                    end
                    data_done = 1'b1;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    // watchdog, 40 cycles per program word
    initial begin
        wait (loaded);
        repeat (int'(prog_len) * 40) @(posedge Clock);
        fail_now("timeout: program did not reach the halt address");
    end

endmodule
